// File: rtl/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DATA_W 32
`define LREG_W 6

// Logical registers 0 to 31 are the general registers.
`define REG_RA 6'd31
`define REG_HI 6'd32
`define REG_LO 6'd33

`define APB_ADDR_W 8
`define ADDR_PC 8'h00
`define ADDR_INST 8'h04

`define UOP_QUEUE_DEPTH 8

`endif

// File: rtl/decodePkg.sv
`include "decode_defs.svh"

package decodePkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00, FN_SRL    = 6'h02, FN_SRA   = 6'h03, FN_SLLV  = 6'h04,
        FN_SRLV    = 6'h06, FN_SRAV   = 6'h07, FN_JR    = 6'h08, FN_JALR  = 6'h09,
        FN_SYSCALL = 6'h0c, FN_BREAK  = 6'h0d, FN_MFHI  = 6'h10, FN_MTHI  = 6'h11,
        FN_MFLO    = 6'h12, FN_MTLO   = 6'h13, FN_MULT  = 6'h18, FN_MULTU = 6'h19,
        FN_DIV     = 6'h1a, FN_DIVU   = 6'h1b, FN_ADD   = 6'h20, FN_ADDU  = 6'h21,
        FN_SUB     = 6'h22, FN_SUBU   = 6'h23, FN_AND   = 6'h24, FN_OR    = 6'h25,
        FN_XOR     = 6'h26, FN_NOR    = 6'h27, FN_SLT   = 6'h2a, FN_SLTU  = 6'h2b
    } functT;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimmT;

    // The decoder selects fields by ranges of this list, so keep groups together.
    typedef enum logic [5:0] {
        U_ADD, U_ADDU, U_SUB, U_SUBU, U_SLT, U_SLTU, U_AND, U_OR, U_XOR, U_NOR,
        U_ADDI, U_ADDIU, U_SLTI, U_SLTIU, U_ANDI, U_ORI, U_XORI, U_LUI,
        U_SLL, U_SRL, U_SRA, U_SLLV, U_SRLV, U_SRAV,
        U_MULTHI, U_MULTLO, U_MULTUHI, U_MULTULO, U_DIVHI, U_DIVLO, U_DIVUHI, U_DIVULO,
        U_MFHI, U_MFLO, U_MTHI, U_MTLO,
        U_BEQ, U_BNE, U_BGEZ, U_BGTZ, U_BLEZ, U_BLTZ, U_BGEZAL, U_BLTZAL,
        U_J, U_JAL, U_JR, U_JALR,
        U_SYSCALL, U_BREAK, U_RESERVED
    } uopCodeT;

    typedef enum logic [1:0] {BR_NORMAL, BR_BR, BR_J, BR_JR} branchTypeT;

    typedef enum logic [1:0] {EXC_NONE, EXC_SYSCALL, EXC_BREAK, EXC_RESERVED} excTypeT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        uopCodeT            uopCode;
        logic [`LREG_W-1:0] srcA;
        logic [`LREG_W-1:0] srcB;
        logic [`LREG_W-1:0] dst;
        logic               srcAEn;
        logic               srcBEn;
        logic               dstEn;
        logic [`DATA_W-1:0] imm;
        branchTypeT         branchType;
        logic [`DATA_W-1:0] branchTarget;
        excTypeT            excType;
    } uopT;

endpackage

// File: rtl/decodeIfs.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

// One instruction word with its pc.
interface instIf;
    logic               valid;
    logic               ready;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] inst;

    modport src (output valid, output pc, output inst, input ready);
    modport dst (input valid, input pc, input inst, output ready);
endinterface

// A uop pair; uop1 is only present together with uop0.
interface uopPairIf;
    logic           valid0;
    logic           valid1;
    decodePkg::uopT uop0;
    decodePkg::uopT uop1;
    logic           ready;

    modport src (output valid0, output valid1, output uop0, output uop1, input ready);
    modport dst (input valid0, input valid1, input uop0, input uop1, output ready);
endinterface

// File: rtl/instApbSlave.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module instApbSlave (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   pSel,
    input  logic                   pEnable,
    input  logic                   pWrite,
    input  logic [`APB_ADDR_W-1:0] pAddr,
    input  logic [`DATA_W-1:0]     pWdata,
    output logic [`DATA_W-1:0]     pRdata,
    output logic                   pReady,
    output logic                   pSlvErr,
    instIf.src                     inst
);
    logic               access;
    logic               hitPc;
    logic               hitInst;
    logic               instWr;
    logic [`DATA_W-1:0] pcQ;

    assign access  = pSel && pEnable;
    assign hitPc   = pAddr == `ADDR_PC;
    assign hitInst = pAddr == `ADDR_INST;
    assign instWr  = access && pWrite && hitInst;

    // The word is offered straight from the access phase.
    assign inst.valid = instWr;
    assign inst.pc    = pcQ;
    assign inst.inst  = pWdata;

    // Wait states while the decoder is busy.
    assign pReady  = access && (!instWr || inst.ready);
    assign pSlvErr = access && !(hitPc || (hitInst && pWrite));
    assign pRdata  = (hitPc && !pWrite) ? pcQ : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ <= '0;
        end else if (access && pWrite && hitPc) begin
            pcQ <= pWdata;
        end else if (instWr && inst.ready) begin
            pcQ <= pcQ + 32'd4;
        end
    end

endmodule

// File: rtl/instDecoder.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module instDecoder (
    input  logic  clk,
    input  logic  arstN,
    instIf.dst    inst,
    uopPairIf.src uops
);
    logic [`DATA_W-1:0] word;
    logic [`DATA_W-1:0] pcPlus4;
    logic [`LREG_W-1:0] rs;
    logic [`LREG_W-1:0] rt;
    logic [`LREG_W-1:0] rd;
    decodePkg::opcodeT  opcode;
    decodePkg::functT   funct;
    decodePkg::regimmT  regimm;
    decodePkg::uopCodeT code;
    decodePkg::uopT     u0;
    decodePkg::uopT     u1;
    decodePkg::uopT     uop0Q;
    decodePkg::uopT     uop1Q;
    logic               isNop;
    logic               isPair;
    logic               take;
    logic               valid0Q;
    logic               valid1Q;

    assign word    = inst.inst;
    assign opcode  = decodePkg::opcodeT'(word[31:26]);
    assign funct   = decodePkg::functT'(word[5:0]);
    assign regimm  = decodePkg::regimmT'(word[20:16]);
    assign rs      = {1'b0, word[25:21]};
    assign rt      = {1'b0, word[20:16]};
    assign rd      = {1'b0, word[15:11]};
    assign pcPlus4 = inst.pc + 32'd4;
    assign isNop   = word == '0;

    always_comb begin
        code = decodePkg::U_RESERVED;
        case (opcode)
            decodePkg::OP_SPECIAL: begin
                case (funct)
                    decodePkg::FN_SLL:     code = decodePkg::U_SLL;
                    decodePkg::FN_SRL:     code = decodePkg::U_SRL;
                    decodePkg::FN_SRA:     code = decodePkg::U_SRA;
                    decodePkg::FN_SLLV:    code = decodePkg::U_SLLV;
                    decodePkg::FN_SRLV:    code = decodePkg::U_SRLV;
                    decodePkg::FN_SRAV:    code = decodePkg::U_SRAV;
                    decodePkg::FN_JR:      code = decodePkg::U_JR;
                    decodePkg::FN_JALR:    code = decodePkg::U_JALR;
                    decodePkg::FN_SYSCALL: code = decodePkg::U_SYSCALL;
                    decodePkg::FN_BREAK:   code = decodePkg::U_BREAK;
                    decodePkg::FN_MFHI:    code = decodePkg::U_MFHI;
                    decodePkg::FN_MTHI:    code = decodePkg::U_MTHI;
                    decodePkg::FN_MFLO:    code = decodePkg::U_MFLO;
                    decodePkg::FN_MTLO:    code = decodePkg::U_MTLO;
                    decodePkg::FN_MULT:    code = decodePkg::U_MULTHI;
                    decodePkg::FN_MULTU:   code = decodePkg::U_MULTUHI;
                    decodePkg::FN_DIV:     code = decodePkg::U_DIVHI;
                    decodePkg::FN_DIVU:    code = decodePkg::U_DIVUHI;
                    decodePkg::FN_ADD:     code = decodePkg::U_ADD;
                    decodePkg::FN_ADDU:    code = decodePkg::U_ADDU;
                    decodePkg::FN_SUB:     code = decodePkg::U_SUB;
                    decodePkg::FN_SUBU:    code = decodePkg::U_SUBU;
                    decodePkg::FN_AND:     code = decodePkg::U_AND;
                    decodePkg::FN_OR:      code = decodePkg::U_OR;
                    decodePkg::FN_XOR:     code = decodePkg::U_XOR;
                    decodePkg::FN_NOR:     code = decodePkg::U_NOR;
                    decodePkg::FN_SLT:     code = decodePkg::U_SLT;
                    decodePkg::FN_SLTU:    code = decodePkg::U_SLTU;
                    default:               code = decodePkg::U_RESERVED;
                endcase
            end
            decodePkg::OP_REGIMM: begin
                case (regimm)
                    decodePkg::RI_BLTZ:   code = decodePkg::U_BLTZ;
                    decodePkg::RI_BGEZ:   code = decodePkg::U_BGEZ;
                    decodePkg::RI_BLTZAL: code = decodePkg::U_BLTZAL;
                    decodePkg::RI_BGEZAL: code = decodePkg::U_BGEZAL;
                    default:              code = decodePkg::U_RESERVED;
                endcase
            end
            decodePkg::OP_J:     code = decodePkg::U_J;
            decodePkg::OP_JAL:   code = decodePkg::U_JAL;
            decodePkg::OP_BEQ:   code = decodePkg::U_BEQ;
            decodePkg::OP_BNE:   code = decodePkg::U_BNE;
            decodePkg::OP_BLEZ:  code = decodePkg::U_BLEZ;
            decodePkg::OP_BGTZ:  code = decodePkg::U_BGTZ;
            decodePkg::OP_ADDI:  code = decodePkg::U_ADDI;
            decodePkg::OP_ADDIU: code = decodePkg::U_ADDIU;
            decodePkg::OP_SLTI:  code = decodePkg::U_SLTI;
            decodePkg::OP_SLTIU: code = decodePkg::U_SLTIU;
            decodePkg::OP_ANDI:  code = decodePkg::U_ANDI;
            decodePkg::OP_ORI:   code = decodePkg::U_ORI;
            decodePkg::OP_XORI:  code = decodePkg::U_XORI;
            decodePkg::OP_LUI:   code = decodePkg::U_LUI;
            default:             code = decodePkg::U_RESERVED;
        endcase
    end

    always_comb begin
        u0         = '0;
        u0.pc      = inst.pc;
        u0.uopCode = code;
        u0.srcAEn  = 1'b1;
        case (code) inside
            [decodePkg::U_SLL:decodePkg::U_SRAV]: u0.srcA = rt;
            decodePkg::U_MFHI: u0.srcA = `REG_HI;
            decodePkg::U_MFLO: u0.srcA = `REG_LO;
            decodePkg::U_LUI, decodePkg::U_J, decodePkg::U_JAL,
            [decodePkg::U_SYSCALL:decodePkg::U_RESERVED]: u0.srcAEn = 1'b0;
            default: u0.srcA = rs;
        endcase
        u0.srcBEn = 1'b1;
        case (code) inside
            [decodePkg::U_SLLV:decodePkg::U_SRAV]: u0.srcB = rs;
            [decodePkg::U_ADD:decodePkg::U_NOR], [decodePkg::U_MULTHI:decodePkg::U_DIVULO],
            decodePkg::U_BEQ, decodePkg::U_BNE: u0.srcB = rt;
            default: u0.srcBEn = 1'b0;
        endcase
        u0.dstEn = 1'b1;
        case (code) inside
            [decodePkg::U_ADD:decodePkg::U_NOR], [decodePkg::U_SLL:decodePkg::U_SRAV],
            decodePkg::U_MFHI, decodePkg::U_MFLO, decodePkg::U_JALR: u0.dst = rd;
            [decodePkg::U_ADDI:decodePkg::U_LUI]: u0.dst = rt;
            [decodePkg::U_MULTHI:decodePkg::U_DIVULO], decodePkg::U_MTHI: u0.dst = `REG_HI;
            decodePkg::U_MTLO: u0.dst = `REG_LO;
            decodePkg::U_BGEZAL, decodePkg::U_BLTZAL, decodePkg::U_JAL: u0.dst = `REG_RA;
            default: u0.dstEn = 1'b0;
        endcase
        case (code) inside
            [decodePkg::U_ADDI:decodePkg::U_SLTIU]: u0.imm = {{16{word[15]}}, word[15:0]};
            [decodePkg::U_ANDI:decodePkg::U_XORI]: u0.imm = {16'h0, word[15:0]};
            decodePkg::U_LUI: u0.imm = {word[15:0], 16'h0};
            [decodePkg::U_SLL:decodePkg::U_SRA]: u0.imm = {27'h0, word[10:6]};
            default: u0.imm = '0;
        endcase
        case (code) inside
            [decodePkg::U_BEQ:decodePkg::U_BLTZAL]: begin
                u0.branchType   = decodePkg::BR_BR;
                u0.branchTarget = pcPlus4 + {{14{word[15]}}, word[15:0], 2'b00};
            end
            decodePkg::U_J, decodePkg::U_JAL: begin
                u0.branchType   = decodePkg::BR_J;
                u0.branchTarget = {pcPlus4[31:28], word[25:0], 2'b00};
            end
            decodePkg::U_JR, decodePkg::U_JALR: u0.branchType = decodePkg::BR_JR;
            default: u0.branchType = decodePkg::BR_NORMAL;
        endcase
        case (code)
            decodePkg::U_SYSCALL:  u0.excType = decodePkg::EXC_SYSCALL;
            decodePkg::U_BREAK:    u0.excType = decodePkg::EXC_BREAK;
            decodePkg::U_RESERVED: u0.excType = decodePkg::EXC_RESERVED;
            default:               u0.excType = decodePkg::EXC_NONE;
        endcase
    end

    // Multiply and divide add a LO uop behind the HI one.
    always_comb begin
        u1     = u0;
        u1.dst = `REG_LO;
        isPair = 1'b1;
        case (code)
            decodePkg::U_MULTHI:  u1.uopCode = decodePkg::U_MULTLO;
            decodePkg::U_MULTUHI: u1.uopCode = decodePkg::U_MULTULO;
            decodePkg::U_DIVHI:   u1.uopCode = decodePkg::U_DIVLO;
            decodePkg::U_DIVUHI:  u1.uopCode = decodePkg::U_DIVULO;
            default:              isPair = 1'b0;
        endcase
    end

    assign inst.ready  = !valid0Q || uops.ready;
    assign take        = inst.valid && inst.ready;
    assign uops.valid0 = valid0Q;
    assign uops.valid1 = valid1Q;
    assign uops.uop0   = uop0Q;
    assign uops.uop1   = uop1Q;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            valid0Q <= 1'b0;
            valid1Q <= 1'b0;
        end else if (take) begin
            valid0Q <= !isNop;
            valid1Q <= !isNop && isPair;
        end else if (uops.ready) begin
            valid0Q <= 1'b0;
            valid1Q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            uop0Q <= u0;
            uop1Q <= u1;
        end
    end

endmodule

// File: rtl/uopQueue.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module uopQueue #(
    parameter int depth = `UOP_QUEUE_DEPTH
) (
    input  logic           clk,
    input  logic           arstN,
    uopPairIf.dst          uops,
    output logic           uopValid,
    input  logic           uopReady,
    output decodePkg::uopT uopData
);
    localparam int ptrW = $clog2(depth);

    decodePkg::uopT  mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] wrPtrNext;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   count;
    logic [1:0]      pushN;
    logic            push;
    logic            pop;

    // A pair is only taken when both halves fit.
    assign uops.ready = count <= (ptrW + 1)'(depth - 2);
    assign push       = uops.valid0 && uops.ready;
    assign pushN      = push ? (uops.valid1 ? 2'd2 : 2'd1) : 2'd0;
    assign pop        = uopValid && uopReady;
    assign wrPtrNext  = wrPtr + 1'b1;

    assign uopValid = count != '0;
    assign uopData  = mem[rdPtr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            wrPtr <= wrPtr + ptrW'(pushN);
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + (ptrW + 1)'(pushN) - (ptrW + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= uops.uop0;
            if (uops.valid1) begin
                mem[wrPtrNext] <= uops.uop1;
            end
        end
    end

endmodule

// File: rtl/decodeTop.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module decodeTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   pSel,
    input  logic                   pEnable,
    input  logic                   pWrite,
    input  logic [`APB_ADDR_W-1:0] pAddr,
    input  logic [`DATA_W-1:0]     pWdata,
    output logic [`DATA_W-1:0]     pRdata,
    output logic                   pReady,
    output logic                   pSlvErr,
    output logic                   uopValid,
    input  logic                   uopReady,
    output decodePkg::uopT         uopData
);
    instIf    instBus ();
    uopPairIf pairBus ();

    instApbSlave u_apb (
        .clk     (clk),
        .arstN   (arstN),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pReady  (pReady),
        .pSlvErr (pSlvErr),
        .inst    (instBus.src)
    );

    instDecoder u_dec (
        .clk   (clk),
        .arstN (arstN),
        .inst  (instBus.dst),
        .uops  (pairBus.src)
    );

    uopQueue u_q (
        .clk      (clk),
        .arstN    (arstN),
        .uops     (pairBus.dst),
        .uopValid (uopValid),
        .uopReady (uopReady),
        .uopData  (uopData)
    );

endmodule

// File: verif/decode_assert.sv
`timescale 1ns/1ns

module decodeAssert (
    input logic           clk,
    input logic           arstN,
    input logic           uopValid,
    input logic           uopReady,
    input decodePkg::uopT uopData,
    input logic           pReady,
    input logic           pSlvErr
);
    // No uop is offered while the design sits in reset.
    resetQuiet: assert property (@(posedge clk) !arstN |-> !uopValid)
        else $error("uopValid is high during reset");

    holdStable: assert property (@(posedge clk) disable iff (!arstN)
        uopValid && !uopReady |=> $stable(uopData))
        else $error("uopData changed while the consumer stalled");

    // An error response is only given on the completing cycle.
    errWithReady: assert property (@(posedge clk) disable iff (!arstN) pSlvErr |-> pReady)
        else $error("pSlvErr is high without pReady");

endmodule

bind decodeTop decodeAssert u_assert (
    .clk      (clk),
    .arstN    (arstN),
    .uopValid (uopValid),
    .uopReady (uopReady),
    .uopData  (uopData),
    .pReady   (pReady),
    .pSlvErr  (pSlvErr)
);

// File: verif/decodeTb.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module decodeTb;
    logic                   clk;
    logic                   arstN;
    logic                   pSel;
    logic                   pEnable;
    logic                   pWrite;
    logic [`APB_ADDR_W-1:0] pAddr;
    logic [`DATA_W-1:0]     pWdata;
    logic [`DATA_W-1:0]     pRdata;
    logic                   pReady;
    logic                   pSlvErr;
    logic                   uopValid;
    logic                   uopReady;
    decodePkg::uopT         uopData;

    decodePkg::uopT expQ[$];
    string          nameQ[$];
    integer         seed = 32'haa43_68e3;
    int             holdCycles = 0;
    int             waitCount = 0;
    int             limitCycles = 0;
    logic           started = 1'b0;

    decodeTop UUT (.clk(clk), .arstN(arstN), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
        .pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr),
        .uopValid(uopValid), .uopReady(uopReady), .uopData(uopData));

    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [255:0] expV, input logic [255:0] actV);
        assert (expV === actV)
            else failRun($sformatf("mismatch %s: expected %0h, actual %0h", name, expV, actV));
    endtask

    // One APB transfer; wait states are counted while pReady is low.
    task automatic apbAccess(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] data,
                             output logic [`DATA_W-1:0] rdata, output logic err);
        @(negedge clk);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = wr;
        pAddr   = addr;
        pWdata  = data;
        @(negedge clk);
        pEnable = 1'b1;
        @(posedge clk);
        while (!pReady) begin
            waitCount++;
            @(posedge clk);
        end
        rdata = pRdata;
        err   = pSlvErr;
        @(negedge clk);
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic readUop(input integer fd, output decodePkg::uopT u);
        logic [`DATA_W-1:0] f [12];
        logic [8*8-1:0]     tag;
        integer             code;
        code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h", tag, f[0], f[1], f[2],
                       f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        assert (code == 13 && tag == "U") else failRun("golden file has a malformed uop line");
        u              = '0;
        u.pc           = f[0];
        u.uopCode      = decodePkg::uopCodeT'(f[1][5:0]);
        u.srcA         = f[2][`LREG_W-1:0];
        u.srcB         = f[3][`LREG_W-1:0];
        u.dst          = f[4][`LREG_W-1:0];
        u.srcAEn       = f[5][0];
        u.srcBEn       = f[6][0];
        u.dstEn        = f[7][0];
        u.imm          = f[8];
        u.branchType   = decodePkg::branchTypeT'(f[9][1:0]);
        u.branchTarget = f[10];
        u.excType      = decodePkg::excTypeT'(f[11][1:0]);
    endtask

    initial begin
        integer               fd;
        integer               code;
        integer               n;
        int                   lines;
        int                   holds;
        logic [8*16-1:0]      tag;
        logic [8*16-1:0]      name;
        logic [8*128-1:0]     line;
        logic [`DATA_W-1:0]   pcVal;
        logic [`DATA_W-1:0]   word;
        logic [`DATA_W-1:0]   rd;
        logic                 err;
        logic                 wr;
        logic [`APB_ADDR_W-1:0] addr;
        decodePkg::uopT       u;
        clk      = 1'b0;
        arstN    = 1'b0;
        pSel     = 1'b0;
        pEnable  = 1'b0;
        pWrite   = 1'b0;
        pAddr    = '0;
        pWdata   = '0;
        uopReady = 1'b0;
        // First pass sizes the watchdog from the number of accesses and hold cycles.
        fd = $fopen("verif/decode_golden.txt", "r");
        assert (fd != 0) else failRun("cannot open verif/decode_golden.txt");
        lines = 0;
        holds = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            code = $fgets(line, fd);
            if (tag == "I" || tag == "N" || tag == "E" || tag == "R") begin
                lines++;
            end else if (tag == "H") begin
                code = $sscanf(line, "%d", n);
                holds += n;
            end
        end
        $fclose(fd);
        limitCycles = 40 * lines + holds + 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN   = 1'b1;
        started = 1'b1;
        fd = $fopen("verif/decode_golden.txt", "r");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "I" || tag == "N") begin
                if (tag == "I") begin
                    code = $fscanf(fd, "%s %h %h %d", name, pcVal, word, n);
                end else begin
                    code = $fscanf(fd, "%s %h %d", name, word, n);
                end
                assert (code == ((tag == "I") ? 4 : 3))
                    else failRun("golden file has a malformed instruction line");
                repeat (n) begin
                    readUop(fd, u);
                    expQ.push_back(u);
                    nameQ.push_back($sformatf("%0s", name));
                end
                if (tag == "I") begin
                    apbAccess(1'b1, `ADDR_PC, pcVal, rd, err);
                    checkEq($sformatf("%0s PC pSlvErr", name), '0, err);
                end
                apbAccess(1'b1, `ADDR_INST, word, rd, err);
                checkEq($sformatf("%0s pSlvErr", name), '0, err);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%s %h %d", name, addr, wr);
                assert (code == 3)
                    else failRun("golden file has a malformed error access line");
                apbAccess(wr, addr, 32'h0, rd, err);
                checkEq($sformatf("%0s pSlvErr", name), 1, err);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%s %h", name, pcVal);
                assert (code == 2)
                    else failRun("golden file has a malformed PC read line");
                apbAccess(1'b0, `ADDR_PC, 32'h0, rd, err);
                checkEq($sformatf("%0s", name), pcVal, rd);
            end else if (tag == "H") begin
                code = $fscanf(fd, "%d", n);
                assert (code == 1)
                    else failRun("golden file has a malformed hold line");
                @(posedge clk);
                holdCycles = n;
                waitCount  = 0;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%s", name);
                assert (code == 1)
                    else failRun("golden file has a malformed stall check line");
                assert (waitCount > 0)
                    else failRun("no APB wait states seen while the uop queue was held full");
            end else begin
                code = $fgets(line, fd);
            end
        end
        $fclose(fd);
        while (expQ.size() != 0) @(posedge clk);
        // A few more cycles so that a stray extra uop is caught.
        repeat (10) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

    // Consumer with random back-pressure, plus held stalls from H lines.
    initial begin
        int             rnd;
        string          nm;
        decodePkg::uopT expU;
        wait (started);
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            if (holdCycles > 0) begin
                uopReady = 1'b0;
                holdCycles--;
            end else begin
                uopReady = rnd[0];
            end
            @(posedge clk);
            if (uopValid && uopReady) begin
                assert (expQ.size() > 0) else failRun("a uop left the queue when none was expected");
                expU = expQ.pop_front();
                nm   = nameQ.pop_front();
                checkEq(nm, expU, uopData);
            end
        end
    end

    initial begin
        wait (started);
        repeat (limitCycles) @(posedge clk);
        failRun("uop stream stalled: the watchdog expired before all expected uops arrived");
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/decodePkg.sv
rtl/decodeIfs.sv
rtl/instApbSlave.sv
rtl/instDecoder.sv
rtl/uopQueue.sv
rtl/decodeTop.sv
verif/decode_assert.sv
verif/decodeTb.sv

// File: run.sh
#!/bin/sh
# Build the decoder testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module decodeTb -o decodeSim && \
./obj_dir/decodeSim || { echo "decoder simulation failed"; exit 1; }

// File: verif/decode_golden.txt
# I name pc inst n | N name inst n | E name addr write | R name pc | H cycles | S name
# U pc uopCode srcA srcB dst srcAEn srcBEn dstEn imm branchType branchTarget excType
I add 00001000 00221820 1
U 00001000 00 01 02 03 1 1 1 00000000 0 00000000 0
N addi 20a4fffe 1
U 00001004 0a 05 00 04 1 0 1 fffffffe 0 00000000 0
N lui 3c081234 1
U 00001008 11 00 00 08 0 0 1 12340000 0 00000000 0
N srlv 01ac5806 1
U 0000100c 16 0c 0d 0b 1 1 1 00000000 0 00000000 0
I beq 00003000 10220004 1
U 00003000 24 01 02 00 1 1 0 00000000 1 00003014 0
N bltzal 0470fffe 1
U 00003004 2b 03 00 1f 1 0 1 00000000 1 00003000 0
N jal 0c000400 1
U 00003008 2d 00 00 1f 0 0 1 00000000 2 00001000 0
N jalr 01003809 1
U 0000300c 2f 08 00 07 1 0 1 00000000 3 00000000 0
I j a0000000 08000010 1
U a0000000 2c 00 00 00 0 0 0 00000000 2 a0000040 0
I nop 00004000 00000000 0
N syscall 0000000c 1
U 00004004 30 00 00 00 0 0 0 00000000 0 00000000 1
N resv fc000000 1
U 00004008 32 00 00 00 0 0 0 00000000 0 00000000 3
E errwr 10 1
E rdinst 04 0
R pcread 0000400c
H 60
I mult 00005000 00220018 2
U 00005000 18 01 02 20 1 1 1 00000000 0 00000000 0
U 00005000 19 01 02 21 1 1 1 00000000 0 00000000 0
N multu 00640019 2
U 00005004 1a 03 04 20 1 1 1 00000000 0 00000000 0
U 00005004 1b 03 04 21 1 1 1 00000000 0 00000000 0
N div 00a6001a 2
U 00005008 1c 05 06 20 1 1 1 00000000 0 00000000 0
U 00005008 1d 05 06 21 1 1 1 00000000 0 00000000 0
N divu 00e8001b 2
U 0000500c 1e 07 08 20 1 1 1 00000000 0 00000000 0
U 0000500c 1f 07 08 21 1 1 1 00000000 0 00000000 0
N sra 000a4943 1
U 00005010 14 0a 00 09 1 0 1 00000005 0 00000000 0
N ori 34e68001 1
U 00005014 0f 07 00 06 1 0 1 00008001 0 00000000 0
S backpressure
